// ==== sound_map_pkg.sv ====
package sound_map_pkg;

   typedef logic [15:0] addr_t;                       // CPU address
   typedef logic [7:0]  byte_t;                       // One register byte

   localparam addr_t CH1_BASE  = 16'hFF10;            // NR10 tone and sweep
   localparam addr_t CH2_BASE  = 16'hFF16;            // NR21 tone
   localparam addr_t CH4_BASE  = 16'hFF20;            // NR41 noise
   localparam addr_t NR50_ADDR = 16'hFF24;            // Terminal volume and Vin
   localparam addr_t NR51_ADDR = 16'hFF25;            // Channel to terminal routing
   localparam addr_t NR52_ADDR = 16'hFF26;            // Master on/off

   localparam int CH1_REGS = 5;                       // NR10 to NR14
   localparam int CH2_REGS = 4;                       // NR21 to NR24
   localparam int CH4_REGS = 4;                       // NR41 to NR44

   localparam int MASTER_BIT  = 7;                    // NR52 all sound on
   localparam int RESTART_BIT = 7;                    // NRx4 initial trigger

   // Bits of each register that hold state
   localparam byte_t FREQ_HI_MASK = 8'h07;            // NRx4 frequency bits 10:8
   localparam byte_t NR10_KEEP    = 8'h7F;            // Bit 7 unused
   localparam byte_t NR41_KEEP    = 8'h3F;            // Length only
   localparam byte_t NRX4_KEEP    = 8'h40 | FREQ_HI_MASK; // Dont_loop plus freq hi
   localparam byte_t NR44_KEEP    = 8'h40;            // Dont_loop only

   function automatic byte_t keep_mask(addr_t a);
      case (a)
         CH1_BASE:                                 return NR10_KEEP;
         CH1_BASE + addr_t'(CH1_REGS - 1),
         CH2_BASE + addr_t'(CH2_REGS - 1):         return NRX4_KEEP;
         CH4_BASE:                                 return NR41_KEEP;
         CH4_BASE + addr_t'(CH4_REGS - 1):         return NR44_KEEP;
         default:                                  return 8'hFF;     // Full byte registers
      endcase
   endfunction

endpackage

// ==== sound_field_pkg.sv ====
package sound_field_pkg;

   // NR10 bits 6:0
   typedef struct packed {
      logic [2:0] sweep_time;                         // 0 means sweep off
      logic       sweep_decreasing;                   // 1 subtracts each shift
      logic [2:0] num_sweep_shifts;                   // Shift amount n
   } sweep_fields_t;

   // NR11 and NR21
   typedef struct packed {
      logic [1:0] wave_duty;                          // 12.5 to 75 percent
      logic [5:0] length_data;                        // Length t1
   } duty_len_fields_t;

   // NRx2 volume envelope
   typedef struct packed {
      logic [3:0] initial_volume;                     // 0 is silent
      logic       envelope_increasing;                // Direction
      logic [2:0] num_envelope_sweeps;                // Step count n
   } envelope_fields_t;

   // NRx4 bit 6 with NRx4 bits 2:0 over NRx3
   typedef struct packed {
      logic        dont_loop;                         // Stop at length expiry
      logic [10:0] frequency_data;                    // 11 bit period value
   } freq_fields_t;

   // NR43 polynomial counter
   typedef struct packed {
      logic [3:0] shift_clock_freq_data;              // Shift clock s
      logic       counter_width;                      // 1 selects 7 bit LFSR
      logic [2:0] freq_dividing_ratio;                // Divider r
   } noise_poly_fields_t;

   // Channel 1 view in register order
   typedef struct packed {
      sweep_fields_t    sweep;                        // NR10
      duty_len_fields_t duty_len;                     // NR11
      envelope_fields_t envelope;                     // NR12
      freq_fields_t     freq;                         // NR14 over NR13
   } tone_sweep_regs_t;

   // Channel 2 view
   typedef struct packed {
      duty_len_fields_t duty_len;                     // NR21
      envelope_fields_t envelope;                     // NR22
      freq_fields_t     freq;                         // NR24 over NR23
   } tone_regs_t;

   // Channel 4 view
   typedef struct packed {
      logic [5:0]         length_data;                // NR41 bits 5:0
      envelope_fields_t   envelope;                   // NR42
      noise_poly_fields_t poly;                       // NR43
      logic               dont_loop;                  // NR44 bit 6
   } noise_regs_t;

   // NR50 then NR51
   typedef struct packed {
      logic       so2_vin;                            // Cartridge Vin to SO2
      logic [2:0] so2_output_level;                   // SO2 master volume
      logic       so1_vin;                            // Cartridge Vin to SO1
      logic [2:0] so1_output_level;                   // SO1 master volume
      logic       so2_ch4_enable;
      logic       so2_ch3_enable;
      logic       so2_ch2_enable;
      logic       so2_ch1_enable;
      logic       so1_ch4_enable;
      logic       so1_ch3_enable;
      logic       so1_ch2_enable;
      logic       so1_ch1_enable;
   } mixer_fields_t;

endpackage

// ==== reg_write_if.sv ====
`timescale 1ns/10ps

// Register write broadcast from the control group to the channel groups
interface reg_write_if;

   sound_map_pkg::addr_t addr;                        // CPU address as issued
   sound_map_pkg::byte_t data;                        // Write byte
   logic                 wen;                         // Write enable gated by master bit
   logic                 clear;                       // High while sound is off

   modport source (
      output addr,
      output data,
      output wen,
      output clear
   );

   modport sink (
      input addr,
      input data,
      input wen,
      input clear
   );

endinterface

// ==== channel_reg_bank.sv ====
`timescale 1ns/10ps

module channel_reg_bank #(
   parameter sound_map_pkg::addr_t BASE     = sound_map_pkg::CH1_BASE,
   parameter int                   NUM_REGS = sound_map_pkg::CH1_REGS,
   parameter type                  fields_t = sound_field_pkg::tone_sweep_regs_t
) (
   input  logic      clk,
   input  logic      rst,
   reg_write_if.sink wr,
   output fields_t   fields,
   output logic      restart
);

   localparam int SLOT_W    = $clog2(NUM_REGS);       // Slot index width
   localparam int VIEW_W    = $bits(fields_t);        // Packed field width
   localparam int LAST_SLOT = NUM_REGS - 1;           // NRx4 slot
   localparam sound_map_pkg::addr_t LAST_ADDR = BASE + sound_map_pkg::addr_t'(LAST_SLOT);
   // Tone channels keep frequency hi bits in NRx4
   localparam logic FREQ_SPLIT =
      |(sound_map_pkg::keep_mask(LAST_ADDR) & sound_map_pkg::FREQ_HI_MASK);

   sound_map_pkg::byte_t regs_q [NUM_REGS];          // Stored bytes, unused bits zero
   sound_map_pkg::addr_t offset;                      // Address minus base
   logic [SLOT_W-1:0]    slot;                        // Target slot
   logic                 hit;                         // Write lands in this group
   logic [VIEW_W-1:0]    view_bits;                   // Kept bits packed MSB first

   // NRx4 goes ahead of NRx3 so the frequency reads as one value
   function automatic int view_slot(int k);
      if (FREQ_SPLIT && k == LAST_SLOT - 1) begin
         return LAST_SLOT;
      end
      if (FREQ_SPLIT && k == LAST_SLOT) begin
         return LAST_SLOT - 1;
      end
      return k;
   endfunction

   assign offset = wr.addr - BASE;
   assign slot   = offset[SLOT_W-1:0];
   assign hit    = wr.wen && (wr.addr >= BASE) && (wr.addr <= LAST_ADDR);

   always_ff @(posedge clk) begin
      if (wr.clear) begin                             // Master off wipes the group
         for (int i = 0; i < NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (hit) begin
         regs_q[slot] <= wr.data & sound_map_pkg::keep_mask(wr.addr); // Drop unused bits
      end
   end

   // One cycle trigger from NRx4 bit 7
   always_ff @(posedge clk) begin
      if (rst) begin
         restart <= 1'b0;
      end else begin
         restart <= hit && (slot == SLOT_W'(LAST_SLOT)) && wr.data[sound_map_pkg::RESTART_BIT];
      end
   end

   // Gather the kept bits of every slot into the packed view
   always_comb begin
      int                   pos;
      int                   s;
      sound_map_pkg::byte_t mask;
      pos       = VIEW_W;
      view_bits = '0;
      for (int k = 0; k < NUM_REGS; k++) begin
         s    = view_slot(k);
         mask = sound_map_pkg::keep_mask(BASE + sound_map_pkg::addr_t'(s));
         for (int b = 7; b >= 0; b--) begin
            if (mask[b]) begin
               pos            = pos - 1;              // Next free bit from the top
               view_bits[pos] = regs_q[s][b];
            end
         end
      end
   end

   // Fields drop in the same cycle the master bit goes low
   assign fields = wr.clear ? fields_t'('0) : fields_t'(view_bits);

endmodule

// ==== sound_ctrl_regs.sv ====
`timescale 1ns/10ps

module sound_ctrl_regs (
   input  logic                           clk,
   input  logic                           rst,
   input  sound_map_pkg::addr_t           reg_addr,
   input  sound_map_pkg::byte_t           reg_data,
   input  logic                           reg_w_enable,
   reg_write_if.source                    wr,
   output sound_field_pkg::mixer_fields_t mixer,
   output logic                           sound_master_enable
);

   logic                 master_q;                    // NR52 bit 7
   sound_map_pkg::byte_t nr50_q;                      // Terminal volume and Vin
   sound_map_pkg::byte_t nr51_q;                      // Channel routing
   logic                 gated_wen;                   // Write allowed while sound is on
   logic                 nr52_sel;
   logic                 nr50_sel;
   logic                 nr51_sel;

   assign nr52_sel  = (reg_addr == sound_map_pkg::NR52_ADDR);
   assign nr50_sel  = (reg_addr == sound_map_pkg::NR50_ADDR);
   assign nr51_sel  = (reg_addr == sound_map_pkg::NR51_ADDR);
   assign gated_wen = reg_w_enable & master_q;        // Stored bit so enabling write gates itself

   // NR52 answers regardless of master state
   always_ff @(posedge clk) begin
      if (rst) begin
         master_q <= 1'b0;
      end else if (reg_w_enable && nr52_sel) begin
         master_q <= reg_data[sound_map_pkg::MASTER_BIT]; // On flags are not stored
      end
   end

   always_ff @(posedge clk) begin
      if (!master_q) begin                            // Held at zero while off
         nr50_q <= '0;
         nr51_q <= '0;
      end else if (gated_wen) begin
         if (nr50_sel) begin
            nr50_q <= reg_data;
         end
         if (nr51_sel) begin
            nr51_q <= reg_data;
         end
      end
   end

   // Broadcast to the channel groups
   assign wr.addr  = reg_addr;
   assign wr.data  = reg_data;
   assign wr.wen   = gated_wen;
   assign wr.clear = ~master_q;                       // Wipes channel storage

   // Mixer reads zero from the cycle sound turns off
   assign mixer = master_q ? sound_field_pkg::mixer_fields_t'({nr50_q, nr51_q})
                           : sound_field_pkg::mixer_fields_t'('0);

   assign sound_master_enable = master_q;

endmodule

// ==== sound_registers.sv ====
`timescale 1ns/10ps

module sound_registers (
   input  logic                 clk,
   input  logic                 rst,
   input  sound_map_pkg::addr_t reg_addr,
   input  sound_map_pkg::byte_t reg_data,
   input  logic                 reg_w_enable,
   // Channel 1 tone and sweep
   output logic [2:0]           ch1_sweep_time,
   output logic                 ch1_sweep_decreasing,
   output logic [2:0]           ch1_num_sweep_shifts,
   output logic [1:0]           ch1_wave_duty,
   output logic [5:0]           ch1_length_data,
   output logic [3:0]           ch1_initial_volume,
   output logic                 ch1_envelope_increasing,
   output logic [2:0]           ch1_num_envelope_sweeps,
   output logic                 ch1_restart,
   output logic                 ch1_dont_loop,
   output logic [10:0]          ch1_frequency_data,
   // Channel 2 tone
   output logic [1:0]           ch2_wave_duty,
   output logic [5:0]           ch2_length_data,
   output logic [3:0]           ch2_initial_volume,
   output logic                 ch2_envelope_increasing,
   output logic [2:0]           ch2_num_envelope_sweeps,
   output logic                 ch2_restart,
   output logic                 ch2_dont_loop,
   output logic [10:0]          ch2_frequency_data,
   // Channel 4 noise
   output logic [5:0]           ch4_length_data,
   output logic [3:0]           ch4_initial_volume,
   output logic                 ch4_envelope_increasing,
   output logic [2:0]           ch4_num_envelope_sweeps,
   output logic [3:0]           ch4_shift_clock_freq_data,
   output logic                 ch4_counter_width,
   output logic [2:0]           ch4_freq_dividing_ratio,
   output logic                 ch4_restart,
   output logic                 ch4_dont_loop,
   // Mixer
   output logic                 so2_vin,
   output logic [2:0]           so2_output_level,
   output logic                 so1_vin,
   output logic [2:0]           so1_output_level,
   output logic                 so2_ch4_enable,
   output logic                 so2_ch3_enable,
   output logic                 so2_ch2_enable,
   output logic                 so2_ch1_enable,
   output logic                 so1_ch4_enable,
   output logic                 so1_ch3_enable,
   output logic                 so1_ch2_enable,
   output logic                 so1_ch1_enable,
   output logic                 sound_master_enable
);

   reg_write_if wr_bus ();                            // Gated write to all channel groups

   sound_field_pkg::tone_sweep_regs_t ch1_fields;
   sound_field_pkg::tone_regs_t       ch2_fields;
   sound_field_pkg::noise_regs_t      ch4_fields;
   sound_field_pkg::mixer_fields_t    mixer;

   sound_ctrl_regs u_ctrl (
      .clk                 (clk),
      .rst                 (rst),
      .reg_addr            (reg_addr),
      .reg_data            (reg_data),
      .reg_w_enable        (reg_w_enable),
      .wr                  (wr_bus),
      .mixer               (mixer),
      .sound_master_enable (sound_master_enable)
   );

   channel_reg_bank #(
      .BASE     (sound_map_pkg::CH1_BASE),
      .NUM_REGS (sound_map_pkg::CH1_REGS),
      .fields_t (sound_field_pkg::tone_sweep_regs_t)
   ) u_ch1 (
      .clk     (clk),
      .rst     (rst),
      .wr      (wr_bus),
      .fields  (ch1_fields),
      .restart (ch1_restart)
   );

   channel_reg_bank #(
      .BASE     (sound_map_pkg::CH2_BASE),
      .NUM_REGS (sound_map_pkg::CH2_REGS),
      .fields_t (sound_field_pkg::tone_regs_t)
   ) u_ch2 (
      .clk     (clk),
      .rst     (rst),
      .wr      (wr_bus),
      .fields  (ch2_fields),
      .restart (ch2_restart)
   );

   channel_reg_bank #(
      .BASE     (sound_map_pkg::CH4_BASE),
      .NUM_REGS (sound_map_pkg::CH4_REGS),
      .fields_t (sound_field_pkg::noise_regs_t)
   ) u_ch4 (
      .clk     (clk),
      .rst     (rst),
      .wr      (wr_bus),
      .fields  (ch4_fields),
      .restart (ch4_restart)
   );

   assign ch1_sweep_time          = ch1_fields.sweep.sweep_time;
   assign ch1_sweep_decreasing    = ch1_fields.sweep.sweep_decreasing;
   assign ch1_num_sweep_shifts    = ch1_fields.sweep.num_sweep_shifts;
   assign ch1_wave_duty           = ch1_fields.duty_len.wave_duty;
   assign ch1_length_data         = ch1_fields.duty_len.length_data;
   assign ch1_initial_volume      = ch1_fields.envelope.initial_volume;
   assign ch1_envelope_increasing = ch1_fields.envelope.envelope_increasing;
   assign ch1_num_envelope_sweeps = ch1_fields.envelope.num_envelope_sweeps;
   assign ch1_dont_loop           = ch1_fields.freq.dont_loop;
   assign ch1_frequency_data      = ch1_fields.freq.frequency_data;

   assign ch2_wave_duty           = ch2_fields.duty_len.wave_duty;
   assign ch2_length_data         = ch2_fields.duty_len.length_data;
   assign ch2_initial_volume      = ch2_fields.envelope.initial_volume;
   assign ch2_envelope_increasing = ch2_fields.envelope.envelope_increasing;
   assign ch2_num_envelope_sweeps = ch2_fields.envelope.num_envelope_sweeps;
   assign ch2_dont_loop           = ch2_fields.freq.dont_loop;
   assign ch2_frequency_data      = ch2_fields.freq.frequency_data;

   assign ch4_length_data           = ch4_fields.length_data;
   assign ch4_initial_volume        = ch4_fields.envelope.initial_volume;
   assign ch4_envelope_increasing   = ch4_fields.envelope.envelope_increasing;
   assign ch4_num_envelope_sweeps   = ch4_fields.envelope.num_envelope_sweeps;
   assign ch4_shift_clock_freq_data = ch4_fields.poly.shift_clock_freq_data;
   assign ch4_counter_width         = ch4_fields.poly.counter_width;
   assign ch4_freq_dividing_ratio   = ch4_fields.poly.freq_dividing_ratio;
   assign ch4_dont_loop             = ch4_fields.dont_loop;

   assign so2_vin          = mixer.so2_vin;
   assign so2_output_level = mixer.so2_output_level;
   assign so1_vin          = mixer.so1_vin;
   assign so1_output_level = mixer.so1_output_level;
   assign so2_ch4_enable   = mixer.so2_ch4_enable;
   assign so2_ch3_enable   = mixer.so2_ch3_enable;
   assign so2_ch2_enable   = mixer.so2_ch2_enable;
   assign so2_ch1_enable   = mixer.so2_ch1_enable;
   assign so1_ch4_enable   = mixer.so1_ch4_enable;
   assign so1_ch3_enable   = mixer.so1_ch3_enable;
   assign so1_ch2_enable   = mixer.so1_ch2_enable;
   assign so1_ch1_enable   = mixer.so1_ch1_enable;

endmodule

// ==== sound_reg_checker.sv ====
`timescale 1ns/10ps

module sound_reg_checker (
   input  logic                 clk,
   input  logic                 rst,
   input  sound_map_pkg::addr_t reg_addr,
   input  sound_map_pkg::byte_t reg_data,
   input  logic                 reg_w_enable,
   input  int                   test_id,                 // Test of the entry on the bus
   input  logic [10:0]          ch1_frequency_data, ch2_frequency_data,
   input  logic [5:0]           ch1_length_data, ch2_length_data, ch4_length_data,
   input  logic [3:0]           ch1_initial_volume, ch2_initial_volume, ch4_initial_volume,
   input  logic [3:0]           ch4_shift_clock_freq_data,
   input  logic [2:0]           ch1_sweep_time, ch1_num_sweep_shifts, ch1_num_envelope_sweeps,
   input  logic [2:0]           ch2_num_envelope_sweeps, ch4_num_envelope_sweeps,
   input  logic [2:0]           ch4_freq_dividing_ratio, so1_output_level, so2_output_level,
   input  logic [1:0]           ch1_wave_duty, ch2_wave_duty,
   input  logic                 ch1_sweep_decreasing, ch1_envelope_increasing,
   input  logic                 ch1_dont_loop, ch1_restart,
   input  logic                 ch2_envelope_increasing, ch2_dont_loop, ch2_restart,
   input  logic                 ch4_envelope_increasing, ch4_counter_width,
   input  logic                 ch4_dont_loop, ch4_restart,
   input  logic                 so1_vin, so2_vin, sound_master_enable,
   input  logic                 so1_ch1_enable, so1_ch2_enable, so1_ch3_enable, so1_ch4_enable,
   input  logic                 so2_ch1_enable, so2_ch2_enable, so2_ch3_enable, so2_ch4_enable,
   output int                   error_count,
   output int                   check_count,
   output int                   test_count,
   output int                   failed_tests
);

   logic [7:0] img [0:63];                               // Byte image of FF00 to FF3F
   logic       master;                                   // NR52 bit 7
   logic [2:0] pulse;                                    // Expected restarts ch4 ch2 ch1
   int         cur_test;                                 // Test of the last sampled edge
   int         last_test;
   int         test_checks;
   int         test_errors;

   // Channel and mixer bytes that hold state
   function automatic bit is_stored(sound_map_pkg::addr_t a);
      return (a >= sound_map_pkg::CH1_BASE && a < sound_map_pkg::CH1_BASE + sound_map_pkg::CH1_REGS)
          || (a >= sound_map_pkg::CH2_BASE && a < sound_map_pkg::CH2_BASE + sound_map_pkg::CH2_REGS)
          || (a >= sound_map_pkg::CH4_BASE && a < sound_map_pkg::CH4_BASE + sound_map_pkg::CH4_REGS)
          || a == sound_map_pkg::NR50_ADDR
          || a == sound_map_pkg::NR51_ADDR;
   endfunction

   task automatic expect_field(string name, logic [15:0] act, logic [15:0] exp);
      check_count++;
      test_checks++;
      if (act !== exp) begin
         $display("FAILED t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic close_test();
      test_count++;
      if (test_errors != 0) begin
         failed_tests++;
      end
      $display("Test %0d %s: %0d checks, %0d errors", last_test,
               (test_errors == 0) ? "pass" : "fail", test_checks, test_errors);
   endtask

   task automatic compare_outputs();
      expect_field("ch1_sweep_time", ch1_sweep_time, img['h10][6:4]);
      expect_field("ch1_sweep_decreasing", ch1_sweep_decreasing, img['h10][3]);
      expect_field("ch1_num_sweep_shifts", ch1_num_sweep_shifts, img['h10][2:0]);
      expect_field("ch1_wave_duty", ch1_wave_duty, img['h11][7:6]);
      expect_field("ch1_length_data", ch1_length_data, img['h11][5:0]);
      expect_field("ch1_initial_volume", ch1_initial_volume, img['h12][7:4]);
      expect_field("ch1_envelope_increasing", ch1_envelope_increasing, img['h12][3]);
      expect_field("ch1_num_envelope_sweeps", ch1_num_envelope_sweeps, img['h12][2:0]);
      expect_field("ch1_frequency_data", ch1_frequency_data, {img['h14][2:0], img['h13]});
      expect_field("ch1_dont_loop", ch1_dont_loop, img['h14][6]);
      expect_field("ch1_restart", ch1_restart, pulse[0]);
      expect_field("ch2_wave_duty", ch2_wave_duty, img['h16][7:6]);
      expect_field("ch2_length_data", ch2_length_data, img['h16][5:0]);
      expect_field("ch2_initial_volume", ch2_initial_volume, img['h17][7:4]);
      expect_field("ch2_envelope_increasing", ch2_envelope_increasing, img['h17][3]);
      expect_field("ch2_num_envelope_sweeps", ch2_num_envelope_sweeps, img['h17][2:0]);
      expect_field("ch2_frequency_data", ch2_frequency_data, {img['h19][2:0], img['h18]});
      expect_field("ch2_dont_loop", ch2_dont_loop, img['h19][6]);
      expect_field("ch2_restart", ch2_restart, pulse[1]);
      expect_field("ch4_length_data", ch4_length_data, img['h20][5:0]);
      expect_field("ch4_initial_volume", ch4_initial_volume, img['h21][7:4]);
      expect_field("ch4_envelope_increasing", ch4_envelope_increasing, img['h21][3]);
      expect_field("ch4_num_envelope_sweeps", ch4_num_envelope_sweeps, img['h21][2:0]);
      expect_field("ch4_shift_clock_freq_data", ch4_shift_clock_freq_data, img['h22][7:4]);
      expect_field("ch4_counter_width", ch4_counter_width, img['h22][3]);
      expect_field("ch4_freq_dividing_ratio", ch4_freq_dividing_ratio, img['h22][2:0]);
      expect_field("ch4_dont_loop", ch4_dont_loop, img['h23][6]);
      expect_field("ch4_restart", ch4_restart, pulse[2]);
      expect_field("so2_vin", so2_vin, img['h24][7]);              // NR50
      expect_field("so2_output_level", so2_output_level, img['h24][6:4]);
      expect_field("so1_vin", so1_vin, img['h24][3]);
      expect_field("so1_output_level", so1_output_level, img['h24][2:0]);
      expect_field("so2_ch4_enable", so2_ch4_enable, img['h25][7]); // NR51
      expect_field("so2_ch3_enable", so2_ch3_enable, img['h25][6]);
      expect_field("so2_ch2_enable", so2_ch2_enable, img['h25][5]);
      expect_field("so2_ch1_enable", so2_ch1_enable, img['h25][4]);
      expect_field("so1_ch4_enable", so1_ch4_enable, img['h25][3]);
      expect_field("so1_ch3_enable", so1_ch3_enable, img['h25][2]);
      expect_field("so1_ch2_enable", so1_ch2_enable, img['h25][1]);
      expect_field("so1_ch1_enable", so1_ch1_enable, img['h25][0]);
      expect_field("sound_master_enable", sound_master_enable, master);
   endtask

   // Model takes the bus at the same edge as the DUT
   always @(posedge clk) begin
      if (rst) begin
         master   = 1'b0;
         pulse    = 3'b000;
         cur_test = 0;
      end else begin
         cur_test = test_id;
         pulse    = 3'b000;                              // Restart lasts one cycle
         if (reg_w_enable && master && is_stored(reg_addr)) begin
            img[reg_addr[5:0]] = reg_data;
            pulse[0] = (reg_addr == 16'hFF14) && reg_data[sound_map_pkg::RESTART_BIT];
            pulse[1] = (reg_addr == 16'hFF19) && reg_data[sound_map_pkg::RESTART_BIT];
            pulse[2] = (reg_addr == 16'hFF23) && reg_data[sound_map_pkg::RESTART_BIT];
         end
         if (reg_w_enable && reg_addr == sound_map_pkg::NR52_ADDR) begin
            master = reg_data[sound_map_pkg::MASTER_BIT]; // Always writable
         end
      end
      if (!master) begin
         foreach (img[i]) begin
            img[i] = 8'h00;                              // Sound off wipes everything
         end
      end
   end

   // Outputs are settled half a cycle after the edge
   always @(negedge clk) begin
      if (cur_test != last_test) begin
         if (last_test != 0) begin
            close_test();
         end
         last_test   = cur_test;
         test_checks = 0;
         test_errors = 0;
      end
      if (!rst && cur_test != 0) begin
         compare_outputs();
      end
   end

endmodule

// ==== tb_sound_registers.sv ====
`timescale 1ns/10ps

module tb_sound_registers;

   localparam int CLK_PERIOD   = 10;                     // ns
   localparam int RESET_CYCLES = 16;
   localparam int NUM_TESTS    = 6;
   localparam int NUM_RANDOM   = 200;                    // Entries in test 6

   typedef struct {
      int                   id;
      sound_map_pkg::addr_t addr;
      sound_map_pkg::byte_t data;
      logic                 we;
   } stim_t;

   logic                 clk;
   logic                 rst;
   sound_map_pkg::addr_t reg_addr;
   sound_map_pkg::byte_t reg_data;
   logic                 reg_w_enable;
   int                   test_id;
   int                   error_count, check_count, test_count, failed_tests;
   logic [10:0]          ch1_frequency_data, ch2_frequency_data;
   logic [5:0]           ch1_length_data, ch2_length_data, ch4_length_data;
   logic [3:0]           ch1_initial_volume, ch2_initial_volume, ch4_initial_volume;
   logic [3:0]           ch4_shift_clock_freq_data;
   logic [2:0]           ch1_sweep_time, ch1_num_sweep_shifts, ch1_num_envelope_sweeps;
   logic [2:0]           ch2_num_envelope_sweeps, ch4_num_envelope_sweeps;
   logic [2:0]           ch4_freq_dividing_ratio, so1_output_level, so2_output_level;
   logic [1:0]           ch1_wave_duty, ch2_wave_duty;
   logic                 ch1_sweep_decreasing, ch1_envelope_increasing;
   logic                 ch1_dont_loop, ch1_restart;
   logic                 ch2_envelope_increasing, ch2_dont_loop, ch2_restart;
   logic                 ch4_envelope_increasing, ch4_counter_width, ch4_dont_loop, ch4_restart;
   logic                 so1_vin, so2_vin, sound_master_enable;
   logic                 so1_ch1_enable, so1_ch2_enable, so1_ch3_enable, so1_ch4_enable;
   logic                 so2_ch1_enable, so2_ch2_enable, so2_ch3_enable, so2_ch4_enable;

   stim_t                stim [$];                       // Stimulus table
   sound_map_pkg::addr_t stored_addrs [15];              // Every writable channel and mixer byte
   logic [31:0]          rng_state;
   bit                   table_built;

   sound_registers u_sound_registers (.*);
   sound_reg_checker u_checker (.*);

   function automatic logic [31:0] xorshift32(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic push_entry(int id, sound_map_pkg::addr_t a, sound_map_pkg::byte_t d, logic we);
      stim_t e;
      e = '{id, a, d, we};
      stim.push_back(e);
   endtask

   task automatic build_table();
      repeat (4) push_entry(1, 16'h0000, 8'h00, 1'b0);   // Idle bus after reset
      foreach (stored_addrs[i]) begin
         push_entry(2, stored_addrs[i], 8'hFF, 1'b1);    // Sound still off
      end
      push_entry(3, sound_map_pkg::NR52_ADDR, 8'h80, 1'b1);
      foreach (stored_addrs[i]) begin
         rng_state = xorshift32(rng_state);
         push_entry(3, stored_addrs[i], rng_state[7:0], 1'b1);
      end
      push_entry(3, 16'hFF15, 8'hFF, 1'b1);              // Holes in the map
      push_entry(3, 16'hFF1F, 8'hFF, 1'b1);
      push_entry(3, 16'hFF27, 8'hFF, 1'b1);
      push_entry(3, 16'hFF30, 8'hFF, 1'b1);
      push_entry(4, 16'hFF14, 8'hC5, 1'b1);              // NR14 trigger
      push_entry(4, 16'h0000, 8'h00, 1'b0);
      push_entry(4, 16'hFF19, 8'h83, 1'b1);              // NR24 trigger
      push_entry(4, 16'h0000, 8'h00, 1'b0);
      push_entry(4, 16'hFF23, 8'hC0, 1'b1);              // NR44 trigger
      push_entry(4, 16'hFF14, 8'h46, 1'b1);              // No trigger
      push_entry(4, 16'h0000, 8'h00, 1'b0);
      push_entry(5, sound_map_pkg::NR52_ADDR, 8'h7F, 1'b1); // Master off
      push_entry(5, 16'h0000, 8'h00, 1'b0);
      foreach (stored_addrs[i]) begin
         push_entry(5, stored_addrs[i], 8'hFF, 1'b1);
      end
      push_entry(5, sound_map_pkg::NR52_ADDR, 8'h80, 1'b1);
      push_entry(5, 16'h0000, 8'h00, 1'b0);
      for (int n = 0; n < NUM_RANDOM; n++) begin
         rng_state = xorshift32(rng_state);
         push_entry(6, stored_addrs[rng_state[11:8] % 15], rng_state[7:0], rng_state[15:12] != 0);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Watchdog sized from the table
   initial begin
      wait (table_built);
      #((stim.size() * 20 + RESET_CYCLES) * CLK_PERIOD);
      $display("Timeout: the %0d table entries did not finish in time", stim.size());
      $display("sim failed");
      $finish;
   end

   initial begin
      rst          = 1'b1;
      reg_addr     = '0;
      reg_data     = '0;
      reg_w_enable = 1'b0;
      test_id      = 0;
      rng_state    = 32'd36;                             // Seed
      stored_addrs = '{16'hFF10, 16'hFF11, 16'hFF12, 16'hFF13, 16'hFF14,
                       16'hFF16, 16'hFF17, 16'hFF18, 16'hFF19,
                       16'hFF20, 16'hFF21, 16'hFF22, 16'hFF23, 16'hFF24, 16'hFF25};
      build_table();
      table_built = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      foreach (stim[i]) begin
         @(posedge clk);
         #1;                                             // Clear of the sampling edge
         test_id      = stim[i].id;
         reg_addr     = stim[i].addr;
         reg_data     = stim[i].data;
         reg_w_enable = stim[i].we;
      end
      @(posedge clk);
      #1;
      test_id      = 0;                                  // Lets the checker close the last test
      reg_w_enable = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               test_count, failed_tests, check_count, error_count);
      if (test_count != NUM_TESTS) begin
         $display("Only %0d of %0d tests reported a result", test_count, NUM_TESTS);
      end
      if (error_count == 0 && failed_tests == 0 && test_count == NUM_TESTS) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
sound_map_pkg.sv
sound_field_pkg.sv
reg_write_if.sv
channel_reg_bank.sv
sound_ctrl_regs.sv
sound_registers.sv
sound_reg_checker.sv
tb_sound_registers.sv

// ==== Bender.yml ====
package:
  name: sound_registers

sources:
  - sound_map_pkg.sv
  - sound_field_pkg.sv
  - reg_write_if.sv
  - channel_reg_bank.sv
  - sound_ctrl_regs.sv
  - sound_registers.sv
  - target: test
    files:
      - sound_reg_checker.sv
      - tb_sound_registers.sv
